//--- source/core_consts.svh
// core constants
// widths, depths and reset values shared by the pipeline slice

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and address width
`define CORE_XLEN 32

// architectural integer registers
`define CORE_REG_COUNT 32
`define CORE_REG_INDEX_BITS 5

// fetch buffer geometry, depth is a power of two
`define CORE_FB_DEPTH 8
`define CORE_FB_PTR_BITS 3

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- source/isa_pkg.sv
// isa package
// RV32I major opcodes and ALU operation codes for the integer subset

`default_nettype none

package isa_pkg;

  // major opcodes handled by decode
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    lui    = 7'b0110111
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    // lui passes the immediate through
    alu_pass_b = 4'd10
  } alu_op_t;

endpackage

`default_nettype wire

//--- source/pipe_pkg.sv
// pipeline package
// data types carried between fetch, decode, issue and execute

`default_nettype none

`include "core_consts.svh"

package pipe_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [`CORE_REG_INDEX_BITS-1:0] reg_index_t;

  // one fetched instruction
  typedef struct packed {
    word_t pc;
    word_t inst;
  } fb_entry_t;

  // decoded micro-op
  typedef struct packed {
    word_t            pc;
    isa_pkg::alu_op_t alu_op;
    reg_index_t       rs1;
    reg_index_t       rs2;
    reg_index_t       rd;
    logic             rd_valid;
    logic             use_imm;
    word_t            imm;
  } uop_t;

endpackage

`default_nettype wire

//--- source/core_ifs.sv
// stage interfaces
// fetch to decode, issue to execute and execute to writeback

`timescale 1ns/1ps
`default_nettype none

// fetch buffer head, decode stalls it
interface fetch_if;
  logic                valid;
  pipe_pkg::fb_entry_t entry;
  logic                stall;

  modport source (output valid, output entry, input stall);
  modport sink (input valid, input entry, output stall);
endinterface

// one-cycle issue strobe, no back-pressure
interface exec_if;
  logic                 valid;
  isa_pkg::alu_op_t     alu_op;
  pipe_pkg::word_t      operand_a;
  pipe_pkg::word_t      operand_b;
  pipe_pkg::reg_index_t rd;
  pipe_pkg::word_t      pc;

  modport source (output valid, output alu_op, output operand_a, output operand_b,
                  output rd, output pc);
  modport sink (input valid, input alu_op, input operand_a, input operand_b,
                input rd, input pc);
endinterface

// writeback strobe, also the retire trace
interface wb_if;
  logic                 valid;
  pipe_pkg::reg_index_t rd;
  pipe_pkg::word_t      data;
  pipe_pkg::word_t      pc;

  modport source (output valid, output rd, output data, output pc);
  modport sink (input valid, input rd, input data, input pc);
endinterface

`default_nettype wire

//--- source/inst_fetch.sv
// instruction fetch
// drives the program counter to the instruction port and queues
// returned words in the fetch buffer FIFO

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module inst_fetch (
  input  logic            clock,
  input  logic            reset,
  input  pipe_pkg::word_t inst_data,
  input  logic            inst_valid,
  output pipe_pkg::word_t inst_addr,
  fetch_if.source         fetch
);

  pipe_pkg::word_t     pc;
  pipe_pkg::fb_entry_t fifo_mem [`CORE_FB_DEPTH];

  logic [`CORE_FB_PTR_BITS-1:0] wr_ptr;
  logic [`CORE_FB_PTR_BITS-1:0] rd_ptr;
  logic [`CORE_FB_PTR_BITS:0]   count;
  logic                         full;
  logic                         push;
  logic                         pop;

  assign full = (count == `CORE_FB_DEPTH);
  // a word arriving while full is dropped, pc stays and memory repeats it
  assign push = inst_valid && !full;
  assign pop  = fetch.valid && !fetch.stall;

  assign inst_addr   = pc;
  assign fetch.valid = (count != '0);
  assign fetch.entry = fifo_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      pc     <= `CORE_RESET_PC;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        pc     <= pc + 32'd4;
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // buffer storage
  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[wr_ptr] <= '{pc: pc, inst: inst_data};
    end
  end

  // a push into a full buffer would overflow the count
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    count <= `CORE_FB_DEPTH);

endmodule

`default_nettype wire

//--- source/inst_decode.sv
// instruction decode
// decode register and RV32I decoder for the ALU subset;
// other encodings are dropped as bubbles

`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  logic           clock,
  input  logic           reset,
  fetch_if.sink          fetch,
  input  logic           issue_stall,
  output logic           decode_valid,
  output pipe_pkg::uop_t decode_uop
);

  logic [31:0]    inst;
  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  logic           load;
  logic           dec_ok;
  pipe_pkg::uop_t dec_uop;

  assign inst   = fetch.entry.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register is free when empty or issue takes its uop
  assign load        = !decode_valid || !issue_stall;
  assign fetch.stall = !load;

  // funct3 to ALU op, alt selects sub / sra
  function automatic isa_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3,
                                                       input logic alt);
    isa_pkg::alu_op_t res;
    case (f3)
      3'b000:  res = alt ? isa_pkg::alu_sub : isa_pkg::alu_add;
      3'b001:  res = isa_pkg::alu_sll;
      3'b010:  res = isa_pkg::alu_slt;
      3'b011:  res = isa_pkg::alu_sltu;
      3'b100:  res = isa_pkg::alu_xor;
      3'b101:  res = alt ? isa_pkg::alu_sra : isa_pkg::alu_srl;
      3'b110:  res = isa_pkg::alu_or;
      default: res = isa_pkg::alu_and;
    endcase
    return res;
  endfunction

  always_comb begin
    dec_uop.pc       = fetch.entry.pc;
    dec_uop.rs1      = inst[19:15];
    dec_uop.rs2      = inst[24:20];
    dec_uop.rd       = inst[11:7];
    dec_uop.rd_valid = (inst[11:7] != 5'd0);
    dec_uop.use_imm  = 1'b0;
    dec_uop.imm      = {{20{inst[31]}}, inst[31:20]};
    dec_uop.alu_op   = isa_pkg::alu_add;
    dec_ok           = 1'b0;
    case (opcode)
      isa_pkg::op: begin
        dec_ok = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        dec_uop.alu_op = alu_from_funct3(funct3, funct7[5]);
      end
      isa_pkg::op_imm: begin
        // rs2 points at x0 so the scoreboard never waits on it
        dec_uop.rs2     = '0;
        dec_uop.use_imm = 1'b1;
        if (funct3 == 3'b001) begin
          dec_ok = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          dec_ok = 1'b1;
        end
        dec_uop.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
      end
      isa_pkg::lui: begin
        dec_uop.rs1     = '0;
        dec_uop.rs2     = '0;
        dec_uop.use_imm = 1'b1;
        dec_uop.imm     = {inst[31:12], 12'b0};
        dec_uop.alu_op  = isa_pkg::alu_pass_b;
        dec_ok          = 1'b1;
      end
      default: dec_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      decode_valid <= 1'b0;
    end else if (load) begin
      // unsupported words are consumed and leave a bubble
      decode_valid <= fetch.valid && dec_ok;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      decode_uop <= dec_uop;
    end
  end

endmodule

`default_nettype wire

//--- source/issue_stage.sv
// issue stage
// scoreboard and integer register file; issues the decoded uop in
// order once its sources and destination are free

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module issue_stage (
  input  logic           clock,
  input  logic           reset,
  input  logic           decode_valid,
  input  pipe_pkg::uop_t decode_uop,
  output logic           issue_stall,
  exec_if.source         exec,
  wb_if.sink             wb
);

  logic [`CORE_REG_COUNT-1:0] busy;
  pipe_pkg::word_t            rf [`CORE_REG_COUNT];

  logic            rs1_free;
  logic            rs2_free;
  logic            rd_free;
  logic            issue;
  pipe_pkg::word_t rs1_data;
  pipe_pkg::word_t rs2_data;

  // no bypass, a register under writeback is still busy this cycle
  assign rs1_free = !busy[decode_uop.rs1];
  assign rs2_free = !busy[decode_uop.rs2];
  // wait out an older write to the same rd
  assign rd_free  = !decode_uop.rd_valid || !busy[decode_uop.rd];

  assign issue       = decode_valid && rs1_free && rs2_free && rd_free;
  assign issue_stall = decode_valid && !(rs1_free && rs2_free && rd_free);

  assign rs1_data = rf[decode_uop.rs1];
  assign rs2_data = rf[decode_uop.rs2];

  // scoreboard and register file
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        rf[i] <= '0;
      end
    end else begin
      if (wb.valid) begin
        busy[wb.rd] <= 1'b0;
        rf[wb.rd]   <= wb.data;
      end
      // x0 is never marked, decode clears rd_valid for it
      if (issue && decode_uop.rd_valid) begin
        busy[decode_uop.rd] <= 1'b1;
      end
    end
  end

  // writes to x0 have no effect and are not sent down the pipe
  always_ff @(posedge clock) begin
    if (reset) begin
      exec.valid <= 1'b0;
    end else begin
      exec.valid <= issue && decode_uop.rd_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      exec.alu_op    <= decode_uop.alu_op;
      exec.operand_a <= rs1_data;
      exec.operand_b <= decode_uop.use_imm ? decode_uop.imm : rs2_data;
      exec.rd        <= decode_uop.rd;
      exec.pc        <= decode_uop.pc;
    end
  end

  a_wb_clears_busy: assert property (@(posedge clock) disable iff (reset)
    wb.valid |-> busy[wb.rd]);

  // two ops in flight never share a destination
  a_no_double_busy: assert property (@(posedge clock) disable iff (reset)
    (exec.valid && wb.valid) |-> (exec.rd != wb.rd));

endmodule

`default_nettype wire

//--- source/alu_pipe.sv
// ALU pipe
// single-cycle integer ALU, result registered onto writeback

`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
  input  logic clock,
  input  logic reset,
  exec_if.sink exec,
  wb_if.source wb
);

  pipe_pkg::word_t result;
  logic [4:0]      shamt;

  assign shamt = exec.operand_b[4:0];

  always_comb begin
    result = '0;
    case (exec.alu_op)
      isa_pkg::alu_add:    result = exec.operand_a + exec.operand_b;
      isa_pkg::alu_sub:    result = exec.operand_a - exec.operand_b;
      isa_pkg::alu_and:    result = exec.operand_a & exec.operand_b;
      isa_pkg::alu_or:     result = exec.operand_a | exec.operand_b;
      isa_pkg::alu_xor:    result = exec.operand_a ^ exec.operand_b;
      isa_pkg::alu_sll:    result = exec.operand_a << shamt;
      isa_pkg::alu_srl:    result = exec.operand_a >> shamt;
      isa_pkg::alu_sra:    result = $signed(exec.operand_a) >>> shamt;
      isa_pkg::alu_slt:    result[0] = $signed(exec.operand_a) < $signed(exec.operand_b);
      isa_pkg::alu_sltu:   result[0] = exec.operand_a < exec.operand_b;
      isa_pkg::alu_pass_b: result = exec.operand_b;
      default:             result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= exec.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (exec.valid) begin
      wb.rd   <= exec.rd;
      wb.data <= result;
      wb.pc   <= exec.pc;
    end
  end

  // x0 writes are filtered at issue
  a_no_x0_wb: assert property (@(posedge clock) disable iff (reset)
    wb.valid |-> (wb.rd != '0));

endmodule

`default_nettype wire

//--- source/core.sv
// core top level
// fetch, decode, issue and ALU stages in order, writeback out as retire trace

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core (
  input  logic                            clock,
  input  logic                            reset,

  // instruction port
  input  logic [`CORE_XLEN-1:0]           inst_data,
  input  logic                            inst_valid,
  output logic [`CORE_XLEN-1:0]           inst_addr,

  // retire trace
  output logic                            retire_valid,
  output logic [`CORE_XLEN-1:0]           retire_pc,
  output logic [`CORE_REG_INDEX_BITS-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]           retire_data
);

  fetch_if fetch_bus ();
  exec_if  exec_bus ();
  wb_if    wb_bus ();

  logic           decode_valid;
  pipe_pkg::uop_t decode_uop;
  logic           issue_stall;

  inst_fetch fetch_stage (
    .clock      (clock),
    .reset      (reset),
    .inst_data  (inst_data),
    .inst_valid (inst_valid),
    .inst_addr  (inst_addr),
    .fetch      (fetch_bus.source)
  );

  inst_decode decode_stage (
    .clock        (clock),
    .reset        (reset),
    .fetch        (fetch_bus.sink),
    .issue_stall  (issue_stall),
    .decode_valid (decode_valid),
    .decode_uop   (decode_uop)
  );

  issue_stage issue (
    .clock        (clock),
    .reset        (reset),
    .decode_valid (decode_valid),
    .decode_uop   (decode_uop),
    .issue_stall  (issue_stall),
    .exec         (exec_bus.source),
    .wb           (wb_bus.sink)
  );

  alu_pipe alu (
    .clock (clock),
    .reset (reset),
    .exec  (exec_bus.sink),
    .wb    (wb_bus.source)
  );

  // writeback doubles as retire, order is program order
  assign retire_valid = wb_bus.valid;
  assign retire_pc    = wb_bus.pc;
  assign retire_rd    = wb_bus.rd;
  assign retire_data  = wb_bus.data;

endmodule

`default_nettype wire

//--- dv/core_tb.sv
// core testbench
// directed tests of the pipeline slice against an in-order reference model,
// with an instruction memory model that answers after a random delay

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb;

  localparam int NUM_TESTS    = 6;
  localparam int TEST_CYCLES  = 400;
  localparam int RUN_LIMIT    = 300;
  localparam int DRAIN_CYCLES = 20;

  logic                 clock;
  logic                 reset;
  pipe_pkg::word_t      inst_data;
  logic                 inst_valid;
  pipe_pkg::word_t      inst_addr;
  logic                 retire_valid;
  pipe_pkg::word_t      retire_pc;
  pipe_pkg::reg_index_t retire_rd;
  pipe_pkg::word_t      retire_data;

  // program image and reference model state
  pipe_pkg::word_t      prog [$];
  pipe_pkg::word_t      regs [`CORE_REG_COUNT];
  pipe_pkg::word_t      exp_pc [$];
  pipe_pkg::reg_index_t exp_rd [$];
  pipe_pkg::word_t      exp_data [$];

  string test_name;
  logic  mem_on;
  logic  zero_delay;
  int    wait_left;

  core dut (
    .clock        (clock),
    .reset        (reset),
    .inst_data    (inst_data),
    .inst_valid   (inst_valid),
    .inst_addr    (inst_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #2 clock = ~clock;

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(string what, pipe_pkg::word_t expected, pipe_pkg::word_t actual);
    if (actual !== expected) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_reg(string what, pipe_pkg::reg_index_t expected,
                           pipe_pkg::reg_index_t actual);
    if (actual !== expected) begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // past the program end: an unsupported opcode, rest of the word from the address
  function automatic pipe_pkg::word_t mem_word(pipe_pkg::word_t addr);
    if (addr[31:2] < prog.size()) begin
      return prog[addr[31:2]];
    end
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  // memory model, one answer per delay window
  always @(posedge clock) begin
    #0.5;
    if (!mem_on) begin
      inst_valid = 1'b0;
      wait_left  = 0;
    end else if (wait_left != 0) begin
      inst_valid = 1'b0;
      wait_left--;
    end else begin
      inst_valid = 1'b1;
      inst_data  = mem_word(inst_addr);
      wait_left  = zero_delay ? 0 : int'($urandom % 4);
    end
  end

  // retire monitor against the head of the expected queue
  always @(negedge clock) begin
    if (!reset && retire_valid) begin
      if (exp_pc.size() == 0) begin
        $display("%s: unexpected retire at pc %h", test_name, retire_pc);
        abort_run();
      end else begin
        check_word("retire_pc", exp_pc.pop_front(), retire_pc);
        check_reg("retire_rd", exp_rd.pop_front(), retire_rd);
        check_word("retire_data", exp_data.pop_front(), retire_data);
      end
    end
  end

  // RV32I ALU rules, shifts use the low 5 bits of b
  function automatic pipe_pkg::word_t alu_ref(isa_pkg::alu_op_t op, pipe_pkg::word_t a,
                                              pipe_pkg::word_t b);
    case (op)
      isa_pkg::alu_add:  return a + b;
      isa_pkg::alu_sub:  return a - b;
      isa_pkg::alu_and:  return a & b;
      isa_pkg::alu_or:   return a | b;
      isa_pkg::alu_xor:  return a ^ b;
      isa_pkg::alu_sll:  return a << b[4:0];
      isa_pkg::alu_srl:  return a >> b[4:0];
      isa_pkg::alu_sra:  return $signed(a) >>> b[4:0];
      isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      default:           return b;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(isa_pkg::alu_op_t op);
    case (op)
      isa_pkg::alu_sll:  return 3'b001;
      isa_pkg::alu_slt:  return 3'b010;
      isa_pkg::alu_sltu: return 3'b011;
      isa_pkg::alu_xor:  return 3'b100;
      isa_pkg::alu_srl:  return 3'b101;
      isa_pkg::alu_sra:  return 3'b101;
      isa_pkg::alu_or:   return 3'b110;
      isa_pkg::alu_and:  return 3'b111;
      default:           return 3'b000;
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(isa_pkg::alu_op_t op);
    return (op == isa_pkg::alu_sub || op == isa_pkg::alu_sra) ? 7'b0100000 : 7'b0000000;
  endfunction

  // x0 writes never retire
  task automatic record(pipe_pkg::reg_index_t rd, pipe_pkg::word_t value);
    if (rd != '0) begin
      regs[rd] = value;
      exp_pc.push_back(pipe_pkg::word_t'(prog.size() * 4));
      exp_rd.push_back(rd);
      exp_data.push_back(value);
    end
  endtask

  task automatic emit_r(isa_pkg::alu_op_t op, pipe_pkg::reg_index_t rd,
                        pipe_pkg::reg_index_t rs1, pipe_pkg::reg_index_t rs2);
    record(rd, alu_ref(op, regs[rs1], regs[rs2]));
    prog.push_back({funct7_of(op), rs2, rs1, funct3_of(op), rd, 7'b0110011});
  endtask

  task automatic emit_i(isa_pkg::alu_op_t op, pipe_pkg::reg_index_t rd,
                        pipe_pkg::reg_index_t rs1, logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    // shift immediates carry funct7 above shamt
    if (op == isa_pkg::alu_sll || op == isa_pkg::alu_srl || op == isa_pkg::alu_sra) begin
      field = {funct7_of(op), imm[4:0]};
    end
    record(rd, alu_ref(op, regs[rs1], {{20{field[11]}}, field}));
    prog.push_back({field, rs1, funct3_of(op), rd, 7'b0010011});
  endtask

  task automatic emit_lui(pipe_pkg::reg_index_t rd, logic [19:0] imm);
    record(rd, {imm, 12'b0});
    prog.push_back({imm, rd, 7'b0110111});
  endtask

  task automatic emit_raw(pipe_pkg::word_t word);
    prog.push_back(word);
  endtask

  task automatic begin_test(string name);
    test_name = name;
    @(negedge clock);
    mem_on = 1'b0;
    @(posedge clock);
    #0.5;
    reset = 1'b1;
    repeat (10) @(posedge clock);
    #0.5;
    reset = 1'b0;
    prog.delete();
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (regs[i]) begin
      regs[i] = '0;
    end
  endtask

  // fetch until every expected write has retired, then watch for extras
  task automatic run_program(logic fast);
    int cycles;
    @(negedge clock);
    zero_delay = fast;
    mem_on     = 1'b1;
    cycles     = 0;
    while (exp_pc.size() != 0 && cycles < RUN_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    repeat (DRAIN_CYCLES) @(posedge clock);
    @(negedge clock);
    mem_on = 1'b0;
    if (exp_pc.size() != 0) begin
      $display("%s: %0d instructions never retired", test_name, exp_pc.size());
      abort_run();
    end
  endtask

  task automatic test_reset_state();
    begin_test("test_reset_state");
    @(negedge clock);
    check_word("inst_addr", `CORE_RESET_PC, inst_addr);
    repeat (20) begin
      @(negedge clock);
      if (retire_valid !== 1'b0) begin
        $display("%s: retire_valid rose with no instruction fetched", test_name);
        abort_run();
      end
    end
    check_word("inst_addr", `CORE_RESET_PC, inst_addr);
  endtask

  task automatic test_alu_ops();
    begin_test("test_alu_ops");
    emit_i(isa_pkg::alu_add, 1, 0, 12'hf9c);   // -100
    emit_i(isa_pkg::alu_add, 2, 0, 12'd37);
    emit_lui(3, 20'h87654);
    emit_i(isa_pkg::alu_add, 3, 3, 12'h321);
    emit_r(isa_pkg::alu_add, 4, 1, 2);
    emit_r(isa_pkg::alu_sub, 5, 1, 2);
    emit_r(isa_pkg::alu_and, 6, 3, 2);
    emit_r(isa_pkg::alu_or, 7, 3, 1);
    emit_r(isa_pkg::alu_xor, 8, 1, 3);
    emit_r(isa_pkg::alu_sll, 9, 3, 2);
    emit_r(isa_pkg::alu_srl, 10, 3, 2);
    emit_r(isa_pkg::alu_sra, 11, 1, 2);
    emit_r(isa_pkg::alu_sra, 12, 3, 2);
    emit_r(isa_pkg::alu_slt, 13, 1, 2);
    emit_r(isa_pkg::alu_sltu, 14, 1, 2);
    emit_i(isa_pkg::alu_and, 15, 3, 12'h0f0);
    emit_i(isa_pkg::alu_or, 16, 2, 12'hf00);   // -256
    emit_i(isa_pkg::alu_xor, 17, 1, 12'h555);
    emit_i(isa_pkg::alu_slt, 18, 1, 12'hf9d);  // -99
    emit_i(isa_pkg::alu_sltu, 19, 2, 12'hfff);
    emit_i(isa_pkg::alu_sll, 20, 3, 12'd7);
    emit_i(isa_pkg::alu_srl, 21, 1, 12'd3);
    emit_i(isa_pkg::alu_sra, 22, 1, 12'd3);
    emit_i(isa_pkg::alu_add, 23, 2, 12'h7ff);
    run_program(1'b0);
  endtask

  task automatic test_lui_and_x0();
    begin_test("test_lui_and_x0");
    emit_lui(5, 20'habcde);
    emit_lui(0, 20'h12345);
    emit_i(isa_pkg::alu_add, 0, 5, 12'd1);
    emit_r(isa_pkg::alu_add, 6, 0, 5);
    emit_i(isa_pkg::alu_add, 7, 0, 12'd0);
    emit_r(isa_pkg::alu_or, 8, 0, 0);
    emit_lui(9, 20'hfffff);
    run_program(1'b0);
  endtask

  task automatic test_dependency_chain();
    begin_test("test_dependency_chain");
    emit_i(isa_pkg::alu_add, 1, 0, 12'd5);
    emit_i(isa_pkg::alu_add, 1, 1, 12'd7);
    emit_r(isa_pkg::alu_add, 2, 1, 1);
    emit_r(isa_pkg::alu_sub, 3, 2, 1);
    emit_r(isa_pkg::alu_sll, 4, 3, 1);
    emit_r(isa_pkg::alu_xor, 5, 4, 2);
    emit_i(isa_pkg::alu_add, 5, 5, 12'hfff);
    emit_i(isa_pkg::alu_sra, 6, 5, 12'd2);
    emit_r(isa_pkg::alu_sltu, 7, 6, 5);
    run_program(1'b0);
  endtask

  // one word per cycle while each op waits on the one before
  task automatic test_fetch_backpressure();
    begin_test("test_fetch_backpressure");
    emit_i(isa_pkg::alu_add, 1, 0, 12'd1);
    for (int i = 0; i < 32; i++) begin
      emit_i(isa_pkg::alu_add, 1, 1, 12'(i + 1));
    end
    emit_r(isa_pkg::alu_add, 2, 1, 1);
    run_program(1'b1);
  endtask

  task automatic test_unsupported_bubble();
    begin_test("test_unsupported_bubble");
    emit_i(isa_pkg::alu_add, 1, 0, 12'd9);
    emit_raw(32'h0000_0000);
    emit_i(isa_pkg::alu_add, 2, 1, 12'd1);
    // sw x2, 0(x1)
    emit_raw(32'h0020_a023);
    // mul x2, x1, x2
    emit_raw(32'h0220_8133);
    emit_r(isa_pkg::alu_add, 3, 1, 2);
    // jal x0, 0
    emit_raw(32'h0000_006f);
    // slli with a bad funct7
    emit_raw(32'h4030_9213);
    emit_i(isa_pkg::alu_add, 4, 3, 12'hffd);
    run_program(1'b0);
  endtask

  initial begin
    void'($urandom(32'hd3fee008));
    clock      = 1'b0;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_data  = '0;
    mem_on     = 1'b0;
    zero_delay = 1'b0;
    wait_left  = 0;
    test_name  = "startup";

    fork
      begin
        #(NUM_TESTS * TEST_CYCLES * 4);
        $display("watchdog expired during %s", test_name);
        abort_run();
      end
    join_none

    test_reset_state();
    test_alu_ops();
    test_lui_and_x0();
    test_dependency_chain();
    test_fetch_backpressure();
    test_unsupported_bubble();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/core_ifs.sv
source/inst_fetch.sv
source/inst_decode.sv
source/issue_stage.sv
source/alu_pipe.sv
source/core.sv
dv/core_tb.sv
